// ==== design/boardDecode.sv ====
////////////////////////////////////////////////////////////////////////////
// onboard selects, output ports 06 and FF, and the CPU data-in mux
// ROM occupies the whole F000-FFFF page, RAM everything else
// after reset memory reads return NOP until the first ROM read is latched
// port writes take effect on the clock that ends pSync
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module boardDecode (
    input  wire logic          pll0_2MHz,
    input  wire logic          n_reset,
    input  wire logic          memCycle,
    input  wire logic          ioCycle,
    input  wire logic          intaCycle,
    input  wire logic          readCycle,
    input  wire logic          writeCycle,
    input  wire logic          pSync,
    input  wire s100Pkg::addrT busAddress,
    input  wire s100Pkg::dataT cpuDataOut,
    input  wire s100Pkg::dataT romData,
    input  wire s100Pkg::dataT ramData,
    input  wire s100Pkg::dataT s100Di,
    output logic               romSel,
    output logic               ramSel,
    output s100Pkg::dataT      cpuDataIn,
    output s100Pkg::dataT      ledBar,
    output s100Pkg::dataT      frontPanel
);

    logic nopActive;                                    // jump-to-ROM state
    logic ioRead;
    logic ioWrite;
    logic ledBarHit;                                    // port 06 on the low address
    logic frontPanelHit;                                // port FF on the low address

    ////////////////////////////////////////////////////////////////////////////
    // memory and port decode
    ////////////////////////////////////////////////////////////////////////////
    assign romSel  = memCycle && (busAddress[15:12] == s100Pkg::ROM_PAGE);
    assign ramSel  = memCycle && !romSel && !nopActive; // RAM hidden while feeding NOPs
    assign ioRead  = ioCycle && readCycle;
    assign ioWrite = ioCycle && writeCycle;

    assign ledBarHit     = busAddress[7:0] == s100Pkg::PORT_LEDBAR;
    assign frontPanelHit = busAddress[7:0] == s100Pkg::PORT_FRONTPANEL;

    ////////////////////////////////////////////////////////////////////////////
    // NOP feed and output ports
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            nopActive  <= 1'b1;                         // CPU runs NOPs up to F000
            ledBar     <= '0;
            frontPanel <= '0;
        end else if (pSync) begin                       // this edge is E1
            if (romSel && readCycle)
                nopActive <= 1'b0;                      // first ROM read ends the feed
            if (ioWrite && ledBarHit)
                ledBar <= cpuDataOut;
            if (ioWrite && frontPanelHit)
                frontPanel <= cpuDataOut;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // CPU data-in mux, first match wins
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (nopActive && memCycle && readCycle)
            cpuDataIn = s100Pkg::NOP_OPCODE;
        else if (romSel)
            cpuDataIn = romData;
        else if (ramSel)
            cpuDataIn = ramData;
        else if (ioRead && ledBarHit)
            cpuDataIn = ledBar;                         // LED bar readback
        else if (ioRead || intaCycle)
            cpuDataIn = s100Di;                         // S-100 I/O board or vector
        else
            cpuDataIn = 8'hFF;                          // floating bus
    end

endmodule

`default_nettype wire

// ==== design/busLatch.sv ====
////////////////////////////////////////////////////////////////////////////
// holding register for one bus payload, loaded once per cycle on pSync
// output holds until the next cycle's pSync edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module busLatch #(
    parameter type payloadT = logic [7:0]
) (
    input  wire logic    pll0_2MHz,
    input  wire logic    n_reset,
    input  wire logic    pSync,
    input  wire payloadT inData,
    output payloadT      outData
);

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset)
            outData <= '0;                              // bus shows all zero
        else if (pSync)
            outData <= inData;                          // capture at E1
    end

endmodule

`default_nettype wire

// ==== design/cycleStatus.sv ====
////////////////////////////////////////////////////////////////////////////
// Z80 strobe decode into cycle kind, status word and bus address
// pins are expected stable while a cycle is active and nWait is low
// pSync is one clock wide, raised on the first edge that sees a cycle
// refresh cycles are not bus cycles and never raise pSync
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cycleStatus (
    input  wire logic          pll0_2MHz,
    input  wire logic          n_reset,
    input  wire logic          nM1,
    input  wire logic          nMreq,
    input  wire logic          nIorq,
    input  wire logic          nRd,
    input  wire logic          nWr,
    input  wire logic          nRfsh,
    input  wire logic          nHalt,
    input  wire s100Pkg::addrT cpuAddress,
    output logic               memCycle,
    output logic               ioCycle,
    output logic               intaCycle,
    output logic               readCycle,
    output logic               writeCycle,
    output logic               pSync,
    output s100Pkg::statusT    statusWord,
    output s100Pkg::addrT      busAddress
);

    logic cycleActive;                                  // any bus cycle on the pins
    logic activeQ;                                      // previous sample of cycleActive

    ////////////////////////////////////////////////////////////////////////////
    // cycle kinds
    ////////////////////////////////////////////////////////////////////////////
    assign memCycle   = !nMreq && nRfsh;                // memory request, not refresh
    assign ioCycle    = !nIorq && nM1;                  // plain port access
    assign intaCycle  = !nIorq && !nM1;                 // Z80 interrupt acknowledge
    assign readCycle  = !nRd;
    assign writeCycle = !nWr;

    assign cycleActive = memCycle || ioCycle || intaCycle;

    ////////////////////////////////////////////////////////////////////////////
    // IEEE-696 status bits
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        statusWord                     = '0;
        statusWord[s100Pkg::STAT_HLTA] = !nHalt;                  // halted
        statusWord[s100Pkg::STAT_OUT]  = ioCycle && writeCycle;   // OUT instruction
        statusWord[s100Pkg::STAT_INP]  = ioCycle && readCycle;    // IN instruction
        statusWord[s100Pkg::STAT_MEMR] = memCycle && readCycle;   // memory read
        statusWord[s100Pkg::STAT_WO]   = !writeCycle;             // high when no write
        statusWord[s100Pkg::STAT_M1]   = !nM1;                    // opcode fetch
        statusWord[s100Pkg::STAT_INTA] = intaCycle;
    end

    // Z80 puts the A register on A15-A8 during port cycles, keep it off the bus
    assign busAddress = (ioCycle || intaCycle) ?
                        {8'h00, cpuAddress[7:0]} : cpuAddress;

    ////////////////////////////////////////////////////////////////////////////
    // pSync marks the start of each cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            activeQ <= 1'b0;                            // idle bus after reset
            pSync   <= 1'b0;
        end else begin
            activeQ <= cycleActive;
            pSync   <= cycleActive && !activeQ;         // rising edge of active
        end
    end

endmodule

`default_nettype wire

// ==== design/s100BusMaster.sv ====
////////////////////////////////////////////////////////////////////////////
// Z80 to S-100 bus master front end, single clock pll0_2MHz
// CPU pins are sampled on the rising edge and must hold while nWait is low
// status and address reach the bus one clock after pSync
// wait values set here, leading zeros count wait states
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module s100BusMaster #(
    parameter s100Pkg::dataT romWaitValue = 8'h3F,      // two waits on ROM
    parameter s100Pkg::dataT ioWaitValue  = 8'h7F       // one wait on I/O
) (
    input  wire logic          pll0_2MHz,
    input  wire logic          n_reset,
    input  wire logic          nM1,                     // Z80 pins
    input  wire logic          nMreq,
    input  wire logic          nIorq,
    input  wire logic          nRd,
    input  wire logic          nWr,
    input  wire logic          nRfsh,
    input  wire logic          nHalt,
    input  wire s100Pkg::addrT cpuAddress,
    input  wire s100Pkg::dataT cpuDataOut,
    input  wire s100Pkg::dataT romData,                 // boot ROM output
    input  wire s100Pkg::dataT ramData,                 // onboard RAM output
    input  wire s100Pkg::dataT s100Di,                  // S-100 data in bus
    input  wire logic          xrdy,
    input  wire logic          rdy,
    output s100Pkg::dataT      cpuDataIn,
    output logic               nWait,
    output logic               pSync,
    output s100Pkg::statusT    s100Status,
    output s100Pkg::addrT      s100Address,
    output logic               romSel,
    output logic               ramSel,
    output s100Pkg::dataT      ledBar,
    output s100Pkg::dataT      frontPanel
);

    logic            memCycle;
    logic            ioCycle;
    logic            intaCycle;
    logic            readCycle;
    logic            writeCycle;
    s100Pkg::statusT statusWord;                        // live status from the pins
    s100Pkg::addrT   busAddress;                        // live address, I/O upper byte zeroed

    ////////////////////////////////////////////////////////////////////////////
    // cycle decode
    ////////////////////////////////////////////////////////////////////////////
    cycleStatus cycleStatus_i (
        .pll0_2MHz, .n_reset,
        .nM1, .nMreq, .nIorq, .nRd, .nWr, .nRfsh, .nHalt,
        .cpuAddress,
        .memCycle, .ioCycle, .intaCycle, .readCycle, .writeCycle,
        .pSync, .statusWord, .busAddress
    );

    boardDecode boardDecode_i (
        .pll0_2MHz, .n_reset,
        .memCycle, .ioCycle, .intaCycle, .readCycle, .writeCycle, .pSync,
        .busAddress, .cpuDataOut, .romData, .ramData, .s100Di,
        .romSel, .ramSel, .cpuDataIn, .ledBar, .frontPanel
    );

    waitStates #(
        .romWaitValue (romWaitValue),
        .ioWaitValue  (ioWaitValue)
    ) waitStates_i (
        .pll0_2MHz, .n_reset, .pSync, .romSel, .ioCycle, .xrdy, .rdy, .nWait
    );

    ////////////////////////////////////////////////////////////////////////////
    // S-100 status and address latches
    ////////////////////////////////////////////////////////////////////////////
    busLatch #(.payloadT(s100Pkg::statusT)) statusLatch (
        .pll0_2MHz, .n_reset, .pSync,
        .inData  (statusWord),
        .outData (s100Status)                           // sHLTA..sINTA to the bus
    );

    busLatch #(.payloadT(s100Pkg::addrT)) addressLatch (
        .pll0_2MHz, .n_reset, .pSync,
        .inData  (busAddress),
        .outData (s100Address)                          // A15-A0 to the bus
    );

endmodule

`default_nettype wire

// ==== design/s100Pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, types and constants for the Z80 S-100 bus master
// status bit positions follow the IEEE-696 status latch order
// only ports 06 and FF are decoded on this board
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package s100Pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths and payload types
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 16;                 // Z80 and S-100 A15-A0

    typedef logic [ADDR_WIDTH-1:0] addrT;           // address word
    typedef logic [7:0]            dataT;           // data byte
    typedef logic [6:0]            statusT;         // seven status bits

    ////////////////////////////////////////////////////////////////////////////
    // status bit positions inside statusT
    ////////////////////////////////////////////////////////////////////////////
    localparam int STAT_HLTA = 0;                   // halt acknowledge
    localparam int STAT_OUT  = 1;                   // output cycle
    localparam int STAT_INP  = 2;                   // input cycle
    localparam int STAT_MEMR = 3;                   // memory read
    localparam int STAT_WO   = 4;                   // write out, active low
    localparam int STAT_M1   = 5;                   // opcode fetch
    localparam int STAT_INTA = 6;                   // interrupt acknowledge

    ////////////////////////////////////////////////////////////////////////////
    // board map
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] ROM_PAGE        = 4'hF;  // A15-A12 of boot ROM
    localparam dataT       PORT_LEDBAR     = 8'h06; // LED bar, with readback
    localparam dataT       PORT_FRONTPANEL = 8'hFF; // front panel LEDs
    localparam dataT       NOP_OPCODE      = 8'h00; // fed to CPU after reset

endpackage

`default_nettype wire

// ==== design/waitStates.sv ====
////////////////////////////////////////////////////////////////////////////
// wait state generator, one 8-bit shift register loaded on pSync
// each leading zero of the loaded value gives one wait after E1
// zeros below the first one bit stretch waits unevenly, so use 7F, 3F, 1F
// xrdy and rdy pull nWait low at any time
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module waitStates #(
    parameter s100Pkg::dataT romWaitValue = 8'h3F,      // two ROM waits
    parameter s100Pkg::dataT ioWaitValue  = 8'h7F       // one I/O wait
) (
    input  wire logic pll0_2MHz,
    input  wire logic n_reset,
    input  wire logic pSync,
    input  wire logic romSel,
    input  wire logic ioCycle,
    input  wire logic xrdy,
    input  wire logic rdy,
    output logic      nWait
);

    s100Pkg::dataT waitReg;                             // MSB is the board wait
    s100Pkg::dataT loadValue;

    assign loadValue = romSel  ? romWaitValue :
                       ioCycle ? ioWaitValue  :
                                 8'hFF;                 // RAM and INTA run at full speed

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset)
            waitReg <= 8'hFF;                           // no wait pending
        else if (pSync)
            waitReg <= loadValue;                       // parallel load at E1
        else
            waitReg <= {waitReg[6:0], 1'b1};            // ones shift in behind
    end

    assign nWait = waitReg[7] && xrdy && rdy;           // low to wait

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the S-100 bus master testbench with Verilator
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module s100BusMaster_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/Vs100BusMaster_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi
exit 0

// ==== verification/s100BusMaster_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// concurrent checks on pSync and nWait, bound into the bus master
// wait checks only apply while xrdy and rdy are high at both ends
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module s100BusMaster_assert (
    input wire logic pll0_2MHz,
    input wire logic n_reset,
    input wire logic pSync,
    input wire logic nWait,
    input wire logic romSel,
    input wire logic ramSel,
    input wire logic xrdy,
    input wire logic rdy
);

    logic readyHigh;                                        // no slave holding off

    assign readyHigh = xrdy && rdy;

    // one clock marker, E0 to E1
    pSyncSingle: assert property (@(posedge pll0_2MHz) disable iff (!n_reset)
        !(pSync && $past(pSync)))
        else $error("pSync stayed high for two cycles");

    // RAM runs without board waits
    ramNoWait: assert property (@(posedge pll0_2MHz) disable iff (!n_reset)
        ($past(pSync && ramSel && readyHigh) && readyHigh) |-> nWait)
        else $error("nWait low after E1 of a RAM cycle");

    // ROM waits are over three clocks after E1
    romWaitEnds: assert property (@(posedge pll0_2MHz) disable iff (!n_reset)
        ($past(pSync && romSel && readyHigh, 3) && readyHigh) |-> nWait)
        else $error("nWait still low three clocks after E1 of a ROM cycle");

endmodule

bind s100BusMaster s100BusMaster_assert s100BusMaster_assert_i (.*);

`default_nettype wire

// ==== verification/s100BusMaster_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the Z80 S-100 bus master front end
// each table row holds one bus cycle for 8 clocks and then 2 idle clocks
// pins change 2 ns after the rising edge
// outputs are read on the falling edge
// ROM, RAM and S-100 data are random per row from one fixed seed
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module s100BusMaster_tb;

    localparam int NUM_ROWS = 12;

    localparam logic [2:0] K_MRD  = 3'd0;                   // memory read
    localparam logic [2:0] K_M1   = 3'd1;                   // opcode fetch
    localparam logic [2:0] K_MWR  = 3'd2;                   // memory write
    localparam logic [2:0] K_IRD  = 3'd3;                   // IN
    localparam logic [2:0] K_IWR  = 3'd4;                   // OUT
    localparam logic [2:0] K_INTA = 3'd5;                   // interrupt acknowledge
    localparam logic [2:0] K_HALT = 3'd6;                   // fetch while halted
    localparam logic [2:0] K_IDLE = 3'd7;                   // no strobes at all

    localparam logic [2:0] S_NOP = 3'd0;                    // expected cpuDataIn source
    localparam logic [2:0] S_ROM = 3'd1;
    localparam logic [2:0] S_RAM = 3'd2;
    localparam logic [2:0] S_LED = 3'd3;
    localparam logic [2:0] S_DI  = 3'd4;
    localparam logic [2:0] S_FF  = 3'd5;

    typedef struct packed {
        logic [2:0]      kind;
        s100Pkg::addrT   addr;
        s100Pkg::dataT   data;                              // cpuDataOut for writes
        logic [2:0]      xrdyHold;                          // clocks after E1 with xrdy low
        logic [2:0]      rdyHold;                           // clocks after E1 with rdy low
        logic [2:0]      waits;                             // board waits after E1
        s100Pkg::statusT status;                            // {INTA,M1,WO,MEMR,INP,OUT,HLTA}
        logic [2:0]      src;
        logic            romExp;
        logic            ramExp;
    } rowT;

    logic            pll0_2MHz = 1'b0;
    logic            n_reset;
    logic            nM1, nMreq, nIorq, nRd, nWr, nRfsh, nHalt;
    logic            xrdy, rdy, nWait, pSync, romSel, ramSel;
    s100Pkg::addrT   cpuAddress, s100Address;
    s100Pkg::dataT   cpuDataOut, romData, ramData, s100Di;
    s100Pkg::dataT   cpuDataIn, ledBar, frontPanel;
    s100Pkg::statusT s100Status;
    s100Pkg::statusT lastStatus;                            // status of the previous row
    s100Pkg::dataT   ledModel, panelModel;                  // expected port contents
    rowT             testRows[NUM_ROWS];
    string           rowNames[NUM_ROWS];

    always #10 pll0_2MHz = !pll0_2MHz;                      // 20 ns period

    s100BusMaster #(
        .romWaitValue (8'h3F),                              // two ROM waits
        .ioWaitValue  (8'h7F)                               // one I/O wait
    ) s100BusMaster_i (.*);

    task automatic checkValue(input string testName, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     testName, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic drivePins(input logic [2:0] kind, input s100Pkg::addrT addr,
                             input s100Pkg::dataT data);
        nM1        = !(kind inside {K_M1, K_HALT, K_INTA});
        nMreq      = !(kind inside {K_MRD, K_M1, K_MWR, K_HALT});
        nIorq      = !(kind inside {K_IRD, K_IWR, K_INTA});
        nRd        = !(kind inside {K_MRD, K_M1, K_IRD, K_HALT});
        nWr        = !(kind inside {K_MWR, K_IWR});
        nHalt      = kind != K_HALT;
        nRfsh      = 1'b1;                                  // refresh not exercised
        cpuAddress = addr;
        cpuDataOut = data;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table with one bus cycle and its expected responses per row
    ////////////////////////////////////////////////////////////////////////////
    task automatic loadRows();
        rowNames[0]  = "nop fetch 0000";
        testRows[0]  = '{K_M1, 16'h0000, 8'h00, 3'd0, 3'd0, 3'd0, 7'h38, S_NOP, 1'b0, 1'b0};
        rowNames[1]  = "rom fetch F000";
        testRows[1]  = '{K_M1, 16'hF000, 8'h00, 3'd0, 3'd0, 3'd2, 7'h38, S_ROM, 1'b1, 1'b0};
        rowNames[2]  = "ram read 1234";
        testRows[2]  = '{K_MRD, 16'h1234, 8'h00, 3'd0, 3'd0, 3'd0, 7'h18, S_RAM, 1'b0, 1'b1};
        rowNames[3]  = "ram write 2345";
        testRows[3]  = '{K_MWR, 16'h2345, 8'hA5, 3'd0, 3'd0, 3'd0, 7'h00, S_RAM, 1'b0, 1'b1};
        rowNames[4]  = "ledbar write";
        testRows[4]  = '{K_IWR, 16'h3406, 8'h5A, 3'd0, 3'd0, 3'd1, 7'h02, S_FF, 1'b0, 1'b0};
        rowNames[5]  = "ledbar readback";
        testRows[5]  = '{K_IRD, 16'h7706, 8'h00, 3'd0, 3'd0, 3'd1, 7'h14, S_LED, 1'b0, 1'b0};
        rowNames[6]  = "panel write";
        testRows[6]  = '{K_IWR, 16'h00FF, 8'hC3, 3'd0, 3'd0, 3'd1, 7'h02, S_FF, 1'b0, 1'b0};
        rowNames[7]  = "port read 10";
        testRows[7]  = '{K_IRD, 16'h5510, 8'h00, 3'd0, 3'd0, 3'd1, 7'h14, S_DI, 1'b0, 1'b0};
        rowNames[8]  = "inta vector";
        testRows[8]  = '{K_INTA, 16'h99AB, 8'h00, 3'd0, 3'd0, 3'd0, 7'h70, S_DI, 1'b0, 1'b0};
        rowNames[9]  = "ram xrdy hold";
        testRows[9]  = '{K_MRD, 16'h4000, 8'h00, 3'd4, 3'd0, 3'd0, 7'h18, S_RAM, 1'b0, 1'b1};
        rowNames[10] = "halt fetch 0100";
        testRows[10] = '{K_HALT, 16'h0100, 8'h00, 3'd0, 3'd0, 3'd0, 7'h39, S_RAM, 1'b0, 1'b1};
        rowNames[11] = "rom rdy hold";
        testRows[11] = '{K_MRD, 16'hF800, 8'h00, 3'd0, 3'd3, 3'd2, 7'h18, S_ROM, 1'b1, 1'b0};
    endtask

    // called and left at 2 ns after a rising edge
    task automatic runRow(input int r);
        rowT           row;
        int            lowCount;
        int            expLow;
        logic          expWait;
        s100Pkg::addrT expAddr;
        s100Pkg::dataT expData;
        row      = testRows[r];
        lowCount = 0;
        drivePins(row.kind, row.addr, row.data);
        romData  = 8'($urandom);
        ramData  = 8'($urandom);
        s100Di   = 8'($urandom);
        xrdy     = row.xrdyHold == 3'd0;                    // S-100 slave holds off
        rdy      = row.rdyHold == 3'd0;
        expLow   = int'(row.waits);
        if (int'(row.xrdyHold) > expLow)
            expLow = int'(row.xrdyHold);                    // longest hold wins
        if (int'(row.rdyHold) > expLow)
            expLow = int'(row.rdyHold);
        expAddr  = (row.kind inside {K_IRD, K_IWR, K_INTA}) ?
                   {8'h00, row.addr[7:0]} : row.addr;       // A15-A8 off the bus on I/O
        case (row.src)
            S_NOP:   expData = s100Pkg::NOP_OPCODE;
            S_ROM:   expData = romData;
            S_RAM:   expData = ramData;
            S_LED:   expData = ledModel;
            S_DI:    expData = s100Di;
            default: expData = 8'hFF;                       // nothing drives the bus
        endcase
        for (int c = 1; c < 8; c++) begin
            @(posedge pll0_2MHz);
            #2;
            if (c - 2 >= int'(row.xrdyHold))
                xrdy = 1'b1;
            if (c - 2 >= int'(row.rdyHold))
                rdy = 1'b1;
            @(negedge pll0_2MHz);
            if (c == 1) begin                               // between E0 and E1
                checkValue(rowNames[r], "pSync at E0", 16'd1, 16'(pSync));
                checkValue(rowNames[r], "status held", 16'(lastStatus), 16'(s100Status));
            end else begin
                if (c == 2) begin                           // just after E1
                    if (row.kind == K_IWR && row.addr[7:0] == s100Pkg::PORT_LEDBAR)
                        ledModel = row.data;
                    if (row.kind == K_IWR && row.addr[7:0] == s100Pkg::PORT_FRONTPANEL)
                        panelModel = row.data;
                    checkValue(rowNames[r], "s100Status", 16'(row.status), 16'(s100Status));
                    checkValue(rowNames[r], "s100Address", expAddr, s100Address);
                    checkValue(rowNames[r], "romSel", 16'(row.romExp), 16'(romSel));
                    checkValue(rowNames[r], "ramSel", 16'(row.ramExp), 16'(ramSel));
                    checkValue(rowNames[r], "cpuDataIn", 16'(expData), 16'(cpuDataIn));
                    checkValue(rowNames[r], "ledBar", 16'(ledModel), 16'(ledBar));
                    checkValue(rowNames[r], "frontPanel", 16'(panelModel), 16'(frontPanel));
                    lastStatus = row.status;
                end
                checkValue(rowNames[r], "pSync after E1", 16'd0, 16'(pSync));
                expWait = !((c - 2 < int'(row.waits)) ||
                            (c - 2 < int'(row.xrdyHold)) ||
                            (c - 2 < int'(row.rdyHold)));
                checkValue(rowNames[r], "nWait", 16'(expWait), 16'(nWait));
                if (!nWait)
                    lowCount++;
            end
        end
        checkValue(rowNames[r], "wait count", 16'(expLow), 16'(lowCount));
        @(posedge pll0_2MHz);
        #2;
        drivePins(K_IDLE, row.addr, 8'h00);                 // bus idle between cycles
        repeat (2) @(posedge pll0_2MHz);
        #2;
    endtask

    initial begin
        int unsigned seedSink;
        seedSink = $urandom(32'h74dd_2daa);                 // one seed for the run
        loadRows();
        drivePins(K_IDLE, 16'h0000, 8'h00);
        n_reset    = 1'b0;
        xrdy       = 1'b1;
        rdy        = 1'b1;
        romData    = 8'h00;
        ramData    = 8'h00;
        s100Di     = 8'h00;
        lastStatus = '0;
        ledModel   = 8'h00;
        panelModel = 8'h00;
        repeat (10) @(posedge pll0_2MHz);
        #2 n_reset = 1'b1;
        @(negedge pll0_2MHz);
        checkValue("reset", "pSync", 16'd0, 16'(pSync));
        checkValue("reset", "nWait", 16'd1, 16'(nWait));
        checkValue("reset", "s100Status", 16'd0, 16'(s100Status));
        checkValue("reset", "s100Address", 16'd0, s100Address);
        checkValue("reset", "ledBar", 16'd0, 16'(ledBar));
        checkValue("reset", "frontPanel", 16'd0, 16'(frontPanel));
        @(posedge pll0_2MHz);
        #2;
        for (int r = 0; r < NUM_ROWS; r++)
            runRow(r);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #((NUM_ROWS * 10 + 20) * 20);                       // 10 clocks per row plus reset
        $display("Timeout: the bus cycles did not finish in the expected time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/s100Pkg.sv
design/busLatch.sv
design/cycleStatus.sv
design/boardDecode.sv
design/waitStates.sv
design/s100BusMaster.sv
verification/s100BusMaster_assert.sv
verification/s100BusMaster_tb.sv
